//--- Bender.yml
package:
  name: osd_overlay

sources:
  - include_dirs:
      - common
    files:
      - common/osdPkg.sv
      - spi/osdSpiClient.sv
      - verilog/osdBuffer.sv
      - video/syncAnalyzer.sv
      - video/osdFetch.sv
      - video/osdMixer.sv
      - verilog/osdTop.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/osdTb.sv

//--- common/osdPkg.sv
`default_nettype none

`include "osd_consts.svh"

package osdPkg;

	typedef struct packed {
		logic [`CHAN_W-1:0] r;
		logic [`CHAN_W-1:0] g;
		logic [`CHAN_W-1:0] b;
	} rgbPixel_t;

	// one pixel clock worth of video
	typedef struct packed {
		rgbPixel_t pixel;
		logic      hSync;
		logic      vSync;
	} videoBeat_t;

	typedef struct packed {
		logic               en;
		logic [`BUF_AW-1:0] addr;
		logic [7:0]         data;
	} bufWrite_t;

	// counters of the current beat and the measured frame shape
	typedef struct packed {
		logic [`CNT_W-1:0] hCnt;
		logic [`CNT_W-1:0] vCnt;
		logic [`CNT_W-1:0] width;
		logic [`CNT_W-1:0] height;
		logic              hPol;
		logic              vPol;
		logic              doublescan;
	} frameGeom_t;

	typedef struct packed {
		videoBeat_t beat;
		logic       inWindow;
		logic [2:0] bitIdx;
	} fetchStage_t;

	// first byte of a transfer read as enable or as line write
	typedef union packed {
		struct packed {
			logic [3:0] op;
			logic [2:0] unused;
			logic       on;
		} enableCmd;
		struct packed {
			logic [4:0] op;
			logic [2:0] line;
		} writeCmd;
	} osdCmd_u;

endpackage

`default_nettype wire

//--- common/osd_consts.svh
`ifndef OSD_CONSTS_SVH
`define OSD_CONSTS_SVH

// bitmap window size in pixels and lines
`define OSD_WIDTH     10'd256
`define OSD_HEIGHT    10'd128

// window offsets from the centred position
`define OSD_X_OFFSET  10'd0
`define OSD_Y_OFFSET  10'd0

// rgb tint of the window with two bits per channel
`define OSD_COLOR     6'h3F

// datapath widths
`define CNT_W         10
`define CHAN_W        6
`define BUF_AW        11

// taller frames than this are doublescanned
`define DSCAN_LINES   10'd350

// command opcodes in the first byte of a transfer
`define CMD_ENABLE_OP 4'b0100
`define CMD_WRITE_OP  5'b00100

`endif

//--- dv/osdTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "osd_consts.svh"

module osdTb;
	import osdPkg::*;

	localparam int ClkPeriod = 8;
	localparam int SpiHalf   = 4;
	localparam int Seed      = 32'h6f07628f;
	localparam int HPulse    = 8;
	localparam int HActive   = 320;
	localparam int VPulse    = 4;
	localparam int FrameA    = (HPulse + HActive) * (VPulse + 240);
	localparam int FrameB    = (HPulse + HActive) * (VPulse + 400);
	localparam int SpiCycles = 3000 * 16 * SpiHalf;
	localparam longint TimeoutCycles = (8 * FrameA + 5 * FrameB + SpiCycles) * 3 / 2;
	localparam logic [`CHAN_W-1:0] Tint = `OSD_COLOR;

	// expected output of one beat while it is inside the DUT
	typedef struct packed {
		logic       check;
		logic [1:0] kind;
		videoBeat_t expected;
	} expectBeat_t;

	logic        clk_sys = 1'b0;
	logic        SPI_SS3;
	logic        spiSck;
	logic        spiCs;
	logic        spiDi;
	videoBeat_t  videoIn;
	videoBeat_t  videoOut;
	logic        osdShown;

	logic [7:0]  modelBuf [0:2047];
	logic        osdOn = 1'b0;
	logic        checkEn = 1'b0;
	logic        reqTall = 1'b0;
	logic        tall = 1'b0;
	int          frameCnt = 0;
	int          modeFrame = 0;
	expectBeat_t pending [$];

	osdTop u_osdTop (
		.clk_sys  (clk_sys),
		.SPI_SS3  (SPI_SS3),
		.spiSck   (spiSck),
		.spiCs    (spiCs),
		.spiDi    (spiDi),
		.videoIn  (videoIn),
		.videoOut (videoOut),
		.osdShown (osdShown)
	);

	always #(ClkPeriod / 2) clk_sys = ~clk_sys;

	task automatic reportMismatch(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("[FAIL] %s expected %h actual %h", testName, expected, actual);
		$display("Test FAILED");
		$fatal(1, "stopped at the first mismatch");
	endtask

	function automatic string kindName(input logic [1:0] kind);
		case (kind)
			2'd1: return "overlay";
			2'd2: return "doublescan";
			default: return "passthrough";
		endcase
	endfunction

	// all inputs move 1 ns after the rising edge
	task automatic waitCycles(input int n);
		repeat (n) @(posedge clk_sys);
		#1;
	endtask

	// ************************************************************
	// SPI host
	// ************************************************************

	task automatic spiShift(input logic [7:0] data, input int nBits);
		for (int i = 0; i < nBits; i++) begin
			spiDi = data[7 - i];
			waitCycles(SpiHalf);
			spiSck = 1'b1;
			waitCycles(SpiHalf);
			spiSck = 1'b0;
		end
	endtask

	task automatic spiStart(input logic [7:0] cmd);
		spiCs = 1'b0;
		waitCycles(SpiHalf);
		spiShift(cmd, 8);
	endtask

	task automatic spiStop();
		waitCycles(SpiHalf);
		spiCs = 1'b1;
		waitCycles(2 * SpiHalf);
	endtask

	// len bytes from the line start, then cutBits of a byte that never completes
	task automatic writeLine(input logic [2:0] line, input int len, input int cutBits);
		logic [7:0] data;
		spiStart({`CMD_WRITE_OP, line});
		for (int n = 0; n < len; n++) begin
			data = $urandom;
			spiShift(data, 8);
			modelBuf[line * 256 + n] = data;
		end
		if (cutBits > 0) begin
			data = $urandom;
			spiShift(data, cutBits);
		end
		spiStop();
	endtask

	task automatic sendJunk(input int payload);
		logic [7:0] cmd;
		logic [7:0] data;
		do begin
			cmd = $urandom;
		end while (cmd[7:4] == `CMD_ENABLE_OP || cmd[7:3] == `CMD_WRITE_OP);
		spiStart(cmd);
		for (int n = 0; n < payload; n++) begin
			data = $urandom;
			spiShift(data, 8);
		end
		spiStop();
		assert (osdShown == osdOn) else reportMismatch("command", osdOn, osdShown);
	endtask

	task automatic setEnable(input logic on);
		checkEn = 1'b0;
		spiStart({`CMD_ENABLE_OP, 3'b000, on});
		spiStop();
		osdOn = on;
		assert (osdShown == on) else reportMismatch("command", on, osdShown);
	endtask

	// geometry is valid once a whole frame of the current mode was measured
	task automatic waitSettled();
		while (tall != reqTall || frameCnt < modeFrame + 2) begin
			waitCycles(1);
		end
	endtask

	task automatic waitFrames(input int n);
		int target;
		target = frameCnt + n;
		while (frameCnt < target) begin
			waitCycles(1);
		end
	endtask

	// ************************************************************
	// reference model of one beat
	// ************************************************************

	function automatic videoBeat_t expectBeat(input videoBeat_t beat, input int x, input int y);
		int         height;
		int         winH;
		int         hStart;
		int         vStart;
		int         col;
		int         row;
		int         addr;
		int         bitIdx;
		logic       ds;
		logic       pix;
		videoBeat_t result;
		result = beat;
		height = tall ? 400 : 240;
		ds = height > `DSCAN_LINES;
		winH = ds ? 2 * `OSD_HEIGHT : `OSD_HEIGHT;
		hStart = (HActive - `OSD_WIDTH) / 2 + `OSD_X_OFFSET;
		vStart = (height - winH) / 2 + `OSD_Y_OFFSET;
		col = x - HPulse - hStart;
		row = y - VPulse - vStart;
		// syncs are negative, so high on both means active video
		if (osdOn && beat.hSync && beat.vSync && col >= 0 && col < `OSD_WIDTH &&
			row >= 0 && row < winH) begin
			addr = (row / (ds ? 32 : 16)) * 256 + col;
			bitIdx = (row / (ds ? 4 : 2)) % 8;
			pix = modelBuf[addr][bitIdx];
			result.pixel.r = {pix, pix, Tint[5:4], beat.pixel.r[5:4]};
			result.pixel.g = {pix, pix, Tint[3:2], beat.pixel.g[5:4]};
			result.pixel.b = {pix, pix, Tint[1:0], beat.pixel.b[5:4]};
		end
		return result;
	endfunction

	// raster generator and output check with three beats in flight
	task automatic runVideo();
		int          x;
		int          y;
		logic        inReset;
		videoBeat_t  beat;
		expectBeat_t head;
		expectBeat_t entry;
		x = 0;
		y = 0;
		forever begin
			@(posedge clk_sys);
			inReset = SPI_SS3;
			#1;
			if (inReset) begin
				pending.delete();
			end else if (pending.size() == 3) begin
				head = pending.pop_front();
				if (head.check) begin
					assert (videoOut == head.expected) else
						reportMismatch(kindName(head.kind), head.expected, videoOut);
				end
			end
			beat.pixel = $urandom;
			beat.hSync = x >= HPulse;
			// vsync moves together with the end of the hsync pulse
			beat.vSync = (x >= HPulse) ? (y >= VPulse) : (y == 0 || y > VPulse);
			videoIn = beat;
			entry.check = checkEn;
			entry.kind = osdOn ? (tall ? 2'd2 : 2'd1) : 2'd0;
			entry.expected = expectBeat(beat, x, y);
			if (!inReset) begin
				pending.push_back(entry);
			end
			x = x + 1;
			if (x == HPulse + HActive) begin
				x = 0;
				y = y + 1;
				if (y == VPulse + (tall ? 400 : 240)) begin
					y = 0;
					frameCnt = frameCnt + 1;
					if (tall != reqTall) begin
						tall = reqTall;
						modeFrame = frameCnt;
					end
				end
			end
		end
	endtask

	// ************************************************************
	// test sequence
	// ************************************************************

	initial begin
		void'($urandom(Seed));
		SPI_SS3 = 1'b1;
		spiSck = 1'b0;
		spiCs = 1'b1;
		spiDi = 1'b0;
		videoIn = '0;
		fork
			runVideo();
		join_none
		waitCycles(8);
		SPI_SS3 = 1'b0;
		assert (osdShown == 1'b0) else reportMismatch("reset", 0, osdShown);
		assert (videoOut == '0) else reportMismatch("reset", 0, videoOut);
		checkEn = 1'b1;
		sendJunk(0);
		sendJunk(2);
		// full bitmap, then partial rewrites of random lines
		for (int line = 0; line < 8; line++) begin
			writeLine(line, 256, 0);
		end
		for (int i = 0; i < 3; i++) begin
			writeLine($urandom_range(7, 0), $urandom_range(200, 1), 0);
		end
		// chip select rises in the middle of a byte
		writeLine($urandom_range(7, 0), $urandom_range(40, 1), $urandom_range(7, 1));
		sendJunk(3);
		setEnable(1'b1);
		sendJunk(1);
		waitSettled();
		checkEn = 1'b1;
		waitFrames(2);
		// 400 line mode doubles the window
		checkEn = 1'b0;
		reqTall = 1'b1;
		waitSettled();
		checkEn = 1'b1;
		waitFrames(2);
		setEnable(1'b0);
		checkEn = 1'b1;
		sendJunk(2);
		waitCycles(1000);
		$display("Test OK");
		$finish;
	end

	initial begin
		#(TimeoutCycles * ClkPeriod);
		$display("Watchdog expired, the test sequence did not finish in time");
		$display("Test FAILED");
		$fatal(1, "timeout");
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+common
common/osdPkg.sv
spi/osdSpiClient.sv
verilog/osdBuffer.sv
video/syncAnalyzer.sv
video/osdFetch.sv
video/osdMixer.sv
verilog/osdTop.sv
dv/osdTb.sv

//--- spi/osdSpiClient.sv
`timescale 1ns/1ps
`default_nettype none

`include "osd_consts.svh"

module osdSpiClient (
	input  logic              clk_sys,
	input  logic              SPI_SS3,
	input  logic              spiSck,
	input  logic              spiCs,
	input  logic              spiDi,
	output osdPkg::bufWrite_t bufWr,
	output logic              osdEnable
);
	import osdPkg::*;

	logic [1:0]         sckSync;
	logic [1:0]         csSync;
	logic [1:0]         diSync;
	logic               sckPrev;
	logic               sckRise;
	logic [3:0]         bitCnt;
	logic [7:0]         shiftReg;
	logic [7:0]         rxByte;
	osdCmd_u            cmd;
	logic               cmdDone;
	logic               wrFire;
	logic [`BUF_AW-1:0] wrAddr;
	logic               wrEn;
	logic [`BUF_AW-1:0] wrAddrQ;
	logic [7:0]         wrData;

	// ************************************************************
	// pin synchronisers
	// ************************************************************

	always_ff @(posedge clk_sys or posedge SPI_SS3) begin
		if (SPI_SS3) begin
			sckSync <= 2'b00;
			csSync  <= 2'b11;
			diSync  <= 2'b00;
			sckPrev <= 1'b0;
		end else begin
			sckSync <= {sckSync[0], spiSck};
			csSync  <= {csSync[0], spiCs};
			diSync  <= {diSync[0], spiDi};
			sckPrev <= sckSync[1];
		end
	end

	// mode 0 takes data on the rising clock edge
	assign sckRise = sckSync[1] & ~sckPrev;

	// msb first byte including the bit being sampled now
	assign rxByte = {shiftReg[6:0], diSync[1]};

	// last bit of a payload byte under a write command
	assign wrFire = sckRise && !csSync[1] && (bitCnt == 4'd15) &&
		(cmd.writeCmd.op == `CMD_WRITE_OP);

	// ************************************************************
	// bit counter and command decode
	// ************************************************************

	always_ff @(posedge clk_sys or posedge SPI_SS3) begin
		if (SPI_SS3) begin
			bitCnt    <= '0;
			cmd       <= '0;
			cmdDone   <= 1'b0;
			wrAddr    <= '0;
			wrEn      <= 1'b0;
			osdEnable <= 1'b0;
		end else begin
			cmdDone <= 1'b0;
			wrEn    <= wrFire;
			if (csSync[1]) begin
				bitCnt <= '0;
				wrAddr <= '0;
			end else begin
				if (sckRise) begin
					// 0..7 is the command byte and payload bytes loop over 8..15
					bitCnt <= (bitCnt < 4'd15) ? bitCnt + 4'd1 : 4'd8;
					if (bitCnt == 4'd7) begin
						cmd     <= rxByte;
						cmdDone <= 1'b1;
					end
				end
				// the command selects one 256 byte line
				if (cmdDone) begin
					wrAddr <= {cmd.writeCmd.line, 8'h00};
				end
				if (wrFire) begin
					wrAddr <= wrAddr + 1'b1;
				end
			end
			if (cmdDone && (cmd.enableCmd.op == `CMD_ENABLE_OP)) begin
				osdEnable <= cmd.enableCmd.on;
			end
		end
	end

	// shift register and write payload
	always_ff @(posedge clk_sys) begin
		if (sckRise) begin
			shiftReg <= rxByte;
		end
		if (wrFire) begin
			wrAddrQ <= wrAddr;
			wrData  <= rxByte;
		end
	end

	assign bufWr = '{en: wrEn, addr: wrAddrQ, data: wrData};

endmodule

`default_nettype wire

//--- verilog/osdBuffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "osd_consts.svh"

module osdBuffer (
	input  logic               clk_sys,
	input  osdPkg::bufWrite_t  bufWr,
	input  logic [`BUF_AW-1:0] rdAddr,
	output logic [7:0]         rdData
);

	localparam int Depth = 2 ** `BUF_AW;

	// 8 lines of 256 bytes where each byte is a column of 8 pixels
	logic [7:0] mem [0:Depth-1];

	always_ff @(posedge clk_sys) begin
		if (bufWr.en) begin
			mem[bufWr.addr] <= bufWr.data;
		end
	end

	// read data follows the address by one cycle
	always_ff @(posedge clk_sys) begin
		rdData <= mem[rdAddr];
	end

endmodule

`default_nettype wire

//--- verilog/osdTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "osd_consts.svh"

module osdTop (
	input  logic               clk_sys,
	input  logic               SPI_SS3,
	input  logic               spiSck,
	input  logic               spiCs,
	input  logic               spiDi,
	input  osdPkg::videoBeat_t videoIn,
	output osdPkg::videoBeat_t videoOut,
	output logic               osdShown
);
	import osdPkg::*;

	bufWrite_t          bufWr;
	logic               osdEnable;
	frameGeom_t         geom;
	logic [`BUF_AW-1:0] rdAddr;
	logic [7:0]         rdData;
	fetchStage_t        stage;

	// ************************************************************
	// host side
	// ************************************************************

	osdSpiClient u_osdSpiClient (
		.clk_sys   (clk_sys),
		.SPI_SS3   (SPI_SS3),
		.spiSck    (spiSck),
		.spiCs     (spiCs),
		.spiDi     (spiDi),
		.bufWr     (bufWr),
		.osdEnable (osdEnable)
	);

	osdBuffer u_osdBuffer (
		.clk_sys (clk_sys),
		.bufWr   (bufWr),
		.rdAddr  (rdAddr),
		.rdData  (rdData)
	);

	// ************************************************************
	// three beat deep video path
	// ************************************************************

	syncAnalyzer u_syncAnalyzer (
		.clk_sys (clk_sys),
		.SPI_SS3 (SPI_SS3),
		.videoIn (videoIn),
		.geom    (geom)
	);

	osdFetch u_osdFetch (
		.clk_sys   (clk_sys),
		.SPI_SS3   (SPI_SS3),
		.videoIn   (videoIn),
		.geom      (geom),
		.osdEnable (osdEnable),
		.rdAddr    (rdAddr),
		.stage     (stage)
	);

	osdMixer u_osdMixer (
		.clk_sys  (clk_sys),
		.SPI_SS3  (SPI_SS3),
		.stage    (stage),
		.rdData   (rdData),
		.videoOut (videoOut)
	);

	assign osdShown = osdEnable;

endmodule

`default_nettype wire

//--- video/osdFetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "osd_consts.svh"

module osdFetch (
	input  logic                clk_sys,
	input  logic                SPI_SS3,
	input  osdPkg::videoBeat_t  videoIn,
	input  osdPkg::frameGeom_t  geom,
	input  logic                osdEnable,
	output logic [`BUF_AW-1:0]  rdAddr,
	output osdPkg::fetchStage_t stage
);

	logic [`CNT_W-1:0]  winH;
	logic [`CNT_W-1:0]  hStart;
	logic [`CNT_W-1:0]  vStart;
	logic [`CNT_W-1:0]  col;
	logic [`CNT_W-1:0]  row;
	logic               hIn;
	logic               vIn;
	logic               syncOff;
	logic               inWindow;
	logic [`BUF_AW-1:0] addrNext;
	logic [2:0]         bitNext;

	// ************************************************************
	// centred window
	// ************************************************************

	assign winH   = geom.doublescan ? (`OSD_HEIGHT << 1) : `OSD_HEIGHT;
	assign hStart = ((geom.width - `OSD_WIDTH) >> 1) + `OSD_X_OFFSET;
	assign vStart = ((geom.height - winH) >> 1) + `OSD_Y_OFFSET;

	assign col = geom.hCnt - hStart;
	assign row = geom.vCnt - vStart;

	// compare the offsets so the window end never wraps
	assign hIn     = (geom.hCnt >= hStart) && (col < `OSD_WIDTH);
	assign vIn     = (geom.vCnt >= vStart) && (row < winH);
	assign syncOff = (videoIn.hSync != geom.hPol) && (videoIn.vSync != geom.vPol);
	assign inWindow = osdEnable && syncOff && hIn && vIn;

	// each bit covers two rows or four under doublescan
	assign addrNext = geom.doublescan ? {row[7:5], col[7:0]} : {row[6:4], col[7:0]};
	assign bitNext  = geom.doublescan ? row[4:2] : row[3:1];

	always_ff @(posedge clk_sys or posedge SPI_SS3) begin
		if (SPI_SS3) begin
			stage <= '0;
		end else begin
			stage <= '{beat: videoIn, inWindow: inWindow, bitIdx: bitNext};
		end
	end

	always_ff @(posedge clk_sys) begin
		rdAddr <= addrNext;
	end

endmodule

`default_nettype wire

//--- video/osdMixer.sv
`timescale 1ns/1ps
`default_nettype none

`include "osd_consts.svh"

module osdMixer (
	input  logic                clk_sys,
	input  logic                SPI_SS3,
	input  osdPkg::fetchStage_t stage,
	input  logic [7:0]          rdData,
	output osdPkg::videoBeat_t  videoOut
);
	import osdPkg::*;

	localparam logic [`CHAN_W-1:0] OsdColor = `OSD_COLOR;

	fetchStage_t stageQ;
	videoBeat_t  blended;
	logic        osdBit;

	// pixel bit twice, tint, then the dimmed source
	function automatic logic [`CHAN_W-1:0] blendChan(
		input logic [`CHAN_W-1:0] chan,
		input logic               pix,
		input logic [1:0]         tint
	);
		return {{2{pix}}, tint, chan[`CHAN_W-1:`CHAN_W-2]};
	endfunction

	assign osdBit = rdData[stageQ.bitIdx];

	always_comb begin
		blended = stageQ.beat;
		if (stageQ.inWindow) begin
			blended.pixel.r = blendChan(stageQ.beat.pixel.r, osdBit, OsdColor[5:4]);
			blended.pixel.g = blendChan(stageQ.beat.pixel.g, osdBit, OsdColor[3:2]);
			blended.pixel.b = blendChan(stageQ.beat.pixel.b, osdBit, OsdColor[1:0]);
		end
	end

	// stageQ lines up with the byte coming out of the buffer
	always_ff @(posedge clk_sys or posedge SPI_SS3) begin
		if (SPI_SS3) begin
			stageQ   <= '0;
			videoOut <= '0;
		end else begin
			stageQ   <= stage;
			videoOut <= blended;
		end
	end

endmodule

`default_nettype wire

//--- video/syncAnalyzer.sv
`timescale 1ns/1ps
`default_nettype none

`include "osd_consts.svh"

module syncAnalyzer (
	input  logic               clk_sys,
	input  logic               SPI_SS3,
	input  osdPkg::videoBeat_t videoIn,
	output osdPkg::frameGeom_t geom
);

	logic              hsPrev;
	logic              vsPrev;
	logic [`CNT_W-1:0] hCntQ;
	logic [`CNT_W-1:0] vCntQ;
	logic [`CNT_W-1:0] hsHigh;
	logic [`CNT_W-1:0] hsLow;
	logic [`CNT_W-1:0] vsHigh;
	logic [`CNT_W-1:0] vsLow;
	logic              hEdge;
	logic              vEdge;
	logic              hLeave;
	logic              hPol;
	logic              vPol;
	logic [`CNT_W-1:0] hCnt;
	logic [`CNT_W-1:0] vCnt;
	logic [`CNT_W-1:0] width;
	logic [`CNT_W-1:0] height;

	// the pulse is the shorter of the two phases
	assign hPol   = hsHigh < hsLow;
	assign vPol   = vsHigh < vsLow;
	assign width  = hPol ? hsLow : hsHigh;
	assign height = vPol ? vsLow : vsHigh;

	assign hEdge  = videoIn.hSync != hsPrev;
	assign vEdge  = videoIn.vSync != vsPrev;
	// end of the hsync pulse starts a new line
	assign hLeave = hEdge && (hsPrev == hPol);

	// counters of the beat now on videoIn
	always_comb begin
		hCnt = hEdge ? '0 : hCntQ + 1'b1;
		if (vEdge) begin
			vCnt = '0;
		end else if (hLeave) begin
			vCnt = vCntQ + 1'b1;
		end else begin
			vCnt = vCntQ;
		end
	end

	always_ff @(posedge clk_sys or posedge SPI_SS3) begin
		if (SPI_SS3) begin
			hsPrev <= 1'b0;
			vsPrev <= 1'b0;
			hCntQ  <= '0;
			vCntQ  <= '0;
			hsHigh <= '0;
			hsLow  <= '0;
			vsHigh <= '0;
			vsLow  <= '0;
		end else begin
			hsPrev <= videoIn.hSync;
			vsPrev <= videoIn.vSync;
			hCntQ  <= hCnt;
			vCntQ  <= vCnt;
			// length of the phase that just ended
			if (hEdge) begin
				if (hsPrev) begin
					hsHigh <= hCntQ + 1'b1;
				end else begin
					hsLow <= hCntQ + 1'b1;
				end
			end
			if (vEdge) begin
				if (vsPrev) begin
					vsHigh <= vCntQ + 1'b1;
				end else begin
					vsLow <= vCntQ + 1'b1;
				end
			end
		end
	end

	assign geom = '{
		hCnt:       hCnt,
		vCnt:       vCnt,
		width:      width,
		height:     height,
		hPol:       hPol,
		vPol:       vPol,
		doublescan: height > `DSCAN_LINES
	};

endmodule

`default_nettype wire
